// ==== zcmt_unit.f ====
hw/zcmt_pkg.sv
hw/cmt_req_if.sv
hw/jvt_csr.sv
hw/cmt_predecode.sv
hw/table_jump_expander.sv
hw/zcmt_unit.sv
dv/table_mem_model.sv
dv/tb_zcmt_unit.sv

// ==== Bender.yml ====
package:
  name: zcmt_unit

sources:
  - hw/zcmt_pkg.sv
  - hw/cmt_req_if.sv
  - hw/jvt_csr.sv
  - hw/cmt_predecode.sv
  - hw/table_jump_expander.sv
  - hw/zcmt_unit.sv
  - target: simulation
    files:
      - dv/table_mem_model.sv
      - dv/tb_zcmt_unit.sv

// ==== dv/zcmt_golden.txt ====
// kind f1 f2 f3 f4 f5 in hex; 1 = JVT write (wdata, readback), 2 = table word (addr, data, fault)
// 3 = item (instr, pc, flags, expected instr, expected flags), flags = {compressed, illegal}
2 00000114 00001104 0 0 0
2 0000017c 00002000 0 0 0
2 00000180 00000ffa 0 0 0
2 000004fc 00082010 0 0 0
2 00000118 0badf00d 1 0 0
2 0000011c 00122018 0 0 0
2 00000854 00003800 0 0 0
2 000008e0 00002f02 0 0 0
1 00000103 00000100 0 0 0
3 00500093 00001000 0 00500093 0
3 0000a016 00001004 2 1000006f 2
3 ffffffff 00001006 1 ffffffff 1
3 00004501 00001008 2 00004501 2
3 0000a082 0000100a 2 ff1ff0ef 2
3 0000a016 00001010 3 0000a016 3
3 0000a016 00001014 0 0000a016 0
3 0000a07e 0000200c 2 ff5ff06f 2
3 0000a3fe 00002010 2 000800ef 2
3 0000a01a 00002014 2 0000a01a 3
3 0000a01e 00002018 2 0000a01e 3
1 00000855 00000840 0 0 0
3 0000a016 00003000 2 0010006f 2
3 0000a0a2 00003002 2 f01ff0ef 2
3 00000013 00003004 0 00000013 0
0 00000000 00000000 0 0 0

// ==== dv/tb_zcmt_unit.sv ====
/*
 * Testbench for the Zcmt expansion unit
 * Replays JVT writes and fetch items from the golden file against random
 * table and output stalls and checks every expanded result in order
 */
module tb_zcmt_unit
  import zcmt_pkg::*;
();

  localparam int unsigned REC_W      = 6;  // Words per golden record
  localparam int unsigned GOLD_DEPTH = 64 * REC_W;
  localparam integer      SEED       = 32'h97cdc51f;

  logic            clk_i = 1'b0;
  logic            rst_ni;
  logic            in_valid_i, in_ready_o;
  logic [XLEN-1:0] in_instr_i, in_pc_i;
  logic            in_compressed_i, in_illegal_i;
  logic            mem_req_valid_o, mem_req_ready_i;
  logic [XLEN-1:0] mem_addr_o, mem_rdata_i;
  logic            mem_rvalid_i, mem_rerr_i;
  logic            csr_we_i;
  logic [XLEN-1:0] csr_wdata_i, csr_rdata_o;
  logic            out_valid_o, out_ready_i;
  logic [XLEN-1:0] out_instr_o;
  logic            out_compressed_o, out_illegal_o;

  logic [XLEN-1:0] gold [GOLD_DEPTH];  // Kind plus five fields per record
  expand_out_t     exp_q [$];          // Expected results in input order
  expand_out_t     got_item;
  integer          seed;               // Output back-pressure
  integer          gap_seed;           // Idle gaps on the input
  int unsigned     n_items, sent_count, recv_count;
  int unsigned     out_errors, csr_errors, file_errors;
  logic            limit_set;          // Watchdog may start counting

  always #5 clk_i = ~clk_i;

  zcmt_unit zcmt_unit_i (.*);

  table_mem_model #(.SEED(SEED)) mem_model_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (mem_req_valid_o),
    .req_ready_o (mem_req_ready_i),
    .addr_i      (mem_addr_o),
    .rvalid_o    (mem_rvalid_i),
    .rdata_o     (mem_rdata_i),
    .rerr_o      (mem_rerr_i)
  );

  task automatic check_out(input expand_out_t got, input expand_out_t exp);
    if (got !== exp) begin
      out_errors++;
      $display("error at %0t: result %0d got %08h c%0b i%0b, expected %08h c%0b i%0b",
               $time, recv_count, got.instruction, got.is_compressed, got.illegal,
               exp.instruction, exp.is_compressed, exp.illegal);
    end
  endtask

  task automatic check_csr(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      csr_errors++;
      $display("error at %0t: JVT readback %08h, expected %08h", $time, got, exp);
    end
  endtask

  // Table words go to the model and expected results to the queue
  task automatic load_golden();
    int unsigned b;
    expand_out_t exp_item;
    b = 0;
    while (b < GOLD_DEPTH && gold[b] != 0) begin
      case (gold[b])
        2: mem_model_i.load_word(gold[b+1], gold[b+2], gold[b+3][0]);
        3: begin
          exp_item = {gold[b+4], gold[b+5][1:0]};  // Flags are {compressed, illegal}
          exp_q.push_back(exp_item);
          n_items++;
        end
        1: ;  // JVT writes are replayed in order later
        default: begin
          file_errors++;
          $display("golden file has an unknown record kind %0h at word %0d", gold[b], b);
        end
      endcase
      b += REC_W;
    end
  endtask

  task automatic send_item(input logic [XLEN-1:0] instr, input logic [XLEN-1:0] pc,
                           input logic [1:0] flags);
    in_valid_i      = 1'b1;
    in_instr_i      = instr;
    in_pc_i         = pc;
    in_compressed_i = flags[1];
    in_illegal_i    = flags[0];
    @(posedge clk_i);
    while (!in_ready_o) @(posedge clk_i);  // Sampled before the edge updates
    sent_count++;
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  task automatic write_csr(input logic [XLEN-1:0] wdata, input logic [XLEN-1:0] exp);
    csr_we_i    = 1'b1;
    csr_wdata_i = wdata;
    @(negedge clk_i);
    csr_we_i    = 1'b0;
    csr_wdata_i = '0;
    check_csr(csr_rdata_o, exp);  // Written on the edge just passed
  endtask

  task automatic run_records();
    int unsigned b;
    b = 0;
    while (b < GOLD_DEPTH && gold[b] != 0) begin
      if (gold[b] == 1) begin
        while (recv_count < sent_count) @(negedge clk_i);  // Later jumps see the new base
        write_csr(gold[b+1], gold[b+2]);
      end else if (gold[b] == 3) begin
        if (($random(gap_seed) & 3) == 0) @(negedge clk_i);  // Idle gap on the input
        send_item(gold[b+1], gold[b+2], gold[b+3][1:0]);
      end
      b += REC_W;
    end
  endtask

  // Output sink with random back-pressure
  always @(negedge clk_i) out_ready_i = ($random(seed) & 3) != 0;

  always @(posedge clk_i) begin
    if (rst_ni && out_valid_o && out_ready_i) begin
      got_item = {out_instr_o, out_compressed_o, out_illegal_o};
      if (exp_q.size() == 0) begin
        out_errors++;
        $display("unexpected result at %0t: output valid with no item outstanding", $time);
      end else begin
        check_out(got_item, exp_q.pop_front());
      end
      recv_count++;
    end
  end

  initial begin
    rst_ni          = 1'b0;
    in_valid_i      = 1'b0;
    in_instr_i      = '0;
    in_pc_i         = '0;
    in_compressed_i = 1'b0;
    in_illegal_i    = 1'b0;
    csr_we_i        = 1'b0;
    csr_wdata_i     = '0;
    out_ready_i     = 1'b0;
    seed            = SEED;
    gap_seed        = SEED;
    n_items         = 0;
    sent_count      = 0;
    recv_count      = 0;
    out_errors      = 0;
    csr_errors      = 0;
    file_errors     = 0;
    limit_set       = 1'b0;
    @(posedge clk_i);  // Model background fill is done by now
    for (int i = 0; i < GOLD_DEPTH; i++) gold[i] = '0;
    $readmemh("dv/zcmt_golden.txt", gold);
    load_golden();
    limit_set = 1'b1;
    repeat (2) @(posedge clk_i);  // Third reset cycle
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_csr(csr_rdata_o, '0);  // Reset value
    run_records();
    while (recv_count < n_items) @(negedge clk_i);
    repeat (10) @(negedge clk_i);  // Catch any stray extra result
    $display("errors: output %0d, csr %0d, golden file %0d", out_errors, csr_errors,
             file_errors);
    if (out_errors + csr_errors + file_errors == 0 && n_items != 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (limit_set);
    repeat (n_items * 40 + 100) @(posedge clk_i);
    $display("timeout: the run did not finish within %0d cycles", n_items * 40 + 100);
    $display("test failed");
    $finish;
  end

endmodule

// ==== dv/table_mem_model.sv ====
/*
 * Jump-table memory model
 * Serves the table port from a word array with random request stalls and
 * a response 1 to 3 cycles after acceptance; faulting words answer with rerr
 */
module table_mem_model #(
  parameter integer SEED = 0
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_valid_i,
  output logic        req_ready_o,
  input  logic [31:0] addr_i,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic        rerr_o
);

  logic [31:0] mem   [1024];  // Window 0x000 to 0xfff
  logic        fault [1024];
  integer      seed;
  logic        pending;       // Accepted request not yet answered
  int unsigned delay;         // Cycles left until the response
  logic [31:0] pend_addr;

  initial begin
    seed        = SEED;
    pending     = 1'b0;
    delay       = 0;
    pend_addr   = '0;
    req_ready_o = 1'b0;
    rvalid_o    = 1'b0;
    rdata_o     = '0;
    rerr_o      = 1'b0;
    for (int i = 0; i < 1024; i++) begin
      mem[i]   = 32'hdead_0000 + i * 4;  // Background word tracks its address
      fault[i] = 1'b0;
    end
  end

  // Table contents from the bench
  task automatic load_word(input logic [31:0] addr, input logic [31:0] data,
                           input logic err);
    mem[addr[11:2]]   = data;
    fault[addr[11:2]] = err;
  endtask

  // Request accepted on this edge
  always @(posedge clk_i) begin
    if (rst_ni && req_valid_i && req_ready_o) begin
      pending   = 1'b1;
      pend_addr = addr_i;
      delay     = 1 + (($random(seed) & 32'h7fff_ffff) % 3);
    end
  end

  // Outputs move on the falling edge
  always @(negedge clk_i) begin
    rvalid_o = 1'b0;
    rerr_o   = 1'b0;
    rdata_o  = '0;
    if (pending) begin
      delay = delay - 1;
      if (delay == 0) begin
        pending  = 1'b0;
        rvalid_o = 1'b1;  // Single-cycle response
        rdata_o  = mem[pend_addr[11:2]];
        rerr_o   = fault[pend_addr[11:2]] || (pend_addr[31:12] != '0);  // Outside window
      end
    end
    req_ready_o = rst_ni && (($random(seed) & 3) != 0);  // Stall about one cycle in four
  end

endmodule

// ==== hw/zcmt_unit.sv ====
/*
 * Zcmt expansion unit
 * Fetch stream in, expanded stream out; ties the JVT register block,
 * the pre-decoder and the table-jump expander to plain ports
 */
module zcmt_unit
  import zcmt_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  // Fetch stream
  input  logic            in_valid_i,
  output logic            in_ready_o,
  input  logic [XLEN-1:0] in_instr_i,
  input  logic [XLEN-1:0] in_pc_i,
  input  logic            in_compressed_i,
  input  logic            in_illegal_i,
  // Jump table port
  output logic            mem_req_valid_o,
  input  logic            mem_req_ready_i,
  output logic [XLEN-1:0] mem_addr_o,
  input  logic            mem_rvalid_i,
  input  logic [XLEN-1:0] mem_rdata_i,
  input  logic            mem_rerr_i,
  // JVT access
  input  logic            csr_we_i,
  input  logic [XLEN-1:0] csr_wdata_i,
  output logic [XLEN-1:0] csr_rdata_o,
  // Expanded stream
  output logic            out_valid_o,
  input  logic            out_ready_i,
  output logic [XLEN-1:0] out_instr_o,
  output logic            out_compressed_o,
  output logic            out_illegal_o
);

  fetch_item_t in_item;
  expand_out_t out_item;
  jvt_t        jvt;

  cmt_req_if cmt_req ();

  assign in_item = '{instruction: in_instr_i, pc: in_pc_i,
                     is_compressed: in_compressed_i, illegal: in_illegal_i};

  assign out_instr_o      = out_item.instruction;
  assign out_compressed_o = out_item.is_compressed;
  assign out_illegal_o    = out_item.illegal;

  jvt_csr jvt_csr_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .we_i    (csr_we_i),
    .wdata_i (csr_wdata_i),
    .rdata_o (csr_rdata_o),
    .jvt_o   (jvt)
  );

  cmt_predecode cmt_predecode_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .in_item_i  (in_item),
    .req        (cmt_req.producer)
  );

  table_jump_expander table_jump_expander_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req             (cmt_req.consumer),
    .jvt_i           (jvt),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_addr_o      (mem_addr_o),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_rdata_i     (mem_rdata_i),
    .mem_rerr_i      (mem_rerr_i),
    .out_valid_o     (out_valid_o),
    .out_ready_i     (out_ready_i),
    .out_o           (out_item)
  );

endmodule

// ==== hw/table_jump_expander.sv ====
/*
 * Table-jump expander
 * Passes plain items to the output register; for cm.jt / cm.jalt it reads
 * the jump table entry and emits the equivalent jal, or flags the original
 * instruction illegal on a bus error or an out-of-range target
 */
module table_jump_expander
  import zcmt_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  cmt_req_if.consumer     req,              // From the pre-decoder
  input  jvt_t            jvt_i,            // Current table base
  output logic            mem_req_valid_o,  // Table read request
  input  logic            mem_req_ready_i,
  output logic [XLEN-1:0] mem_addr_o,
  input  logic            mem_rvalid_i,     // Table response
  input  logic [XLEN-1:0] mem_rdata_i,
  input  logic            mem_rerr_i,
  output logic            out_valid_o,      // Expanded stream
  input  logic            out_ready_i,
  output expand_out_t     out_o
);

  tj_state_e state_d, state_q;

  logic            out_valid_q;
  expand_out_t     out_q;
  logic [XLEN-1:0] tbl_addr_q;  // Latched at transfer so later JVT writes leave it alone
  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] instr_q;     // Kept for the illegal case
  jt_kind_e        kind_q;

  logic                  accept;
  logic                  out_free;
  logic                  load_plain;
  logic                  load_jump;
  logic [XLEN-1:0]       tbl_addr_d;
  logic [XLEN-1:0]       offset;
  logic                  offset_ok;
  logic [REG_ADDR_W-1:0] rd;
  expand_out_t           jump_res;

  // Output register empty, or emptying this cycle
  assign out_free  = !out_valid_q || out_ready_i;
  assign req.ready = (state_q == TJ_IDLE) && out_free;
  assign accept    = req.valid && req.ready;

  assign load_plain = accept && !req.is_table;
  assign load_jump  = (state_q == TJ_WAIT) && mem_rvalid_i;

  // Entry address is base plus 4 times index
  assign tbl_addr_d = {jvt_i.base, {JVT_MODE_W{1'b0}}}
                    + {{(XLEN-INDEX_W-2){1'b0}}, req.index, 2'b00};

  // Jal formed from the returned entry
  assign offset    = mem_rdata_i - pc_q;
  assign offset_ok = offset[XLEN-1:JAL_OFF_W-1] == {(XLEN-JAL_OFF_W+1){offset[JAL_OFF_W-1]}};
  assign rd        = (kind_q == JT_LINK) ? RD_RA : RD_ZERO;

  always_comb begin
    jump_res.is_compressed = 1'b1;  // Stands in for a 16-bit instruction
    if (mem_rerr_i || !offset_ok) begin
      jump_res.instruction = instr_q;
      jump_res.illegal     = 1'b1;
    end else begin
      jump_res.instruction = {offset[20], offset[10:1], offset[11], offset[19:12],
                              rd, OPCODE_JAL};
      jump_res.illegal     = 1'b0;
    end
  end

  // FSM
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      TJ_IDLE: if (accept && req.is_table) state_d = TJ_REQ;
      TJ_REQ:  if (mem_req_ready_i) state_d = TJ_WAIT;  // Request accepted
      TJ_WAIT: if (mem_rvalid_i) state_d = TJ_IDLE;     // Result written this edge
      default: state_d = TJ_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= TJ_IDLE;
      out_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (load_plain || load_jump) begin
        out_valid_q <= 1'b1;
      end else if (out_ready_i) begin
        out_valid_q <= 1'b0;  // Drained downstream
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk_i) begin
    if (accept) begin
      tbl_addr_q <= tbl_addr_d;
      pc_q       <= req.item.pc;
      instr_q    <= req.item.instruction;
      kind_q     <= req.kind;
    end
    if (load_plain) begin
      out_q.instruction   <= req.item.instruction;  // Unchanged, flags included
      out_q.is_compressed <= req.item.is_compressed;
      out_q.illegal       <= req.item.illegal;
    end else if (load_jump) begin
      out_q <= jump_res;
    end
  end

  assign mem_req_valid_o = (state_q == TJ_REQ);
  assign mem_addr_o      = tbl_addr_q;
  assign out_valid_o     = out_valid_q;
  assign out_o           = out_q;

  // A table fetch only runs with the output register already drained
  a_req_state: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_o |-> !out_valid_o
  ) else $error("table request with output pending");

  // Memory never answers without an outstanding request
  a_rvalid_wait: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem_rvalid_i |-> state_q == TJ_WAIT
  ) else $error("table response outside TJ_WAIT");

  a_out_hold: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_o)
  ) else $error("output changed while stalled");

endmodule

// ==== hw/cmt_predecode.sv ====
/*
 * Table-jump pre-decoder
 * One-entry pipeline register on the fetch stream that flags cm.jt and
 * cm.jalt, extracts the table index and picks the link kind
 */
module cmt_predecode
  import zcmt_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        in_valid_i,  // Fetch item valid
  output logic        in_ready_o,  // Stage can take an item
  input  fetch_item_t in_item_i,   // Fetch item
  cmt_req_if.producer req          // Decoded item to the expander
);

  logic               valid_q;
  fetch_item_t        item_q;
  logic               is_table_q;
  jt_kind_e           kind_q;
  logic [INDEX_W-1:0] index_q;

  logic               load;
  logic               is_table_d;
  jt_kind_e           kind_d;
  logic [INDEX_W-1:0] index_d;

  // Empty, or the held item moves on this cycle
  assign in_ready_o = !valid_q || req.ready;
  assign load       = in_valid_i && in_ready_o;

  // Decode of the compressed encoding
  always_comb begin
    index_d    = in_item_i.instruction[9:2];
    is_table_d = in_item_i.is_compressed && !in_item_i.illegal
              && (in_item_i.instruction[15:13] == CMT_FUNCT3)
              && (in_item_i.instruction[12:10] == 3'b000)  // cm.jt / cm.jalt group
              && (in_item_i.instruction[1:0] == CMT_OP);
    kind_d     = (index_d >= JALT_MIN) ? JT_LINK : JT_PLAIN;  // Upper indices link to ra
  end

  // Occupancy
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (req.ready) begin
      valid_q <= 1'b0;  // Item taken, nothing new
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (load) begin
      item_q     <= in_item_i;
      is_table_q <= is_table_d;
      kind_q     <= kind_d;
      index_q    <= index_d;
    end
  end

  assign req.valid    = valid_q;
  assign req.item     = item_q;
  assign req.is_table = is_table_q;
  assign req.kind     = kind_q;
  assign req.index    = index_q;

  // Fetch keeps a stalled item valid and unchanged until its transfer
  a_in_hold: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_item_i)
  ) else $error("fetch item dropped or changed while stalled");

endmodule

// ==== hw/jvt_csr.sv ====
/*
 * JVT register block
 * Holds the jump vector table base and mode, written through a plain
 * CSR port; mode is WARL and only jump mode 0 is accepted
 */
module jvt_csr
  import zcmt_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            we_i,     // Write strobe from the CSR file
  input  logic [XLEN-1:0] wdata_i,  // Write data
  output logic [XLEN-1:0] rdata_o,  // Readback
  output jvt_t            jvt_o     // Current base and mode to the expander
);

  jvt_t jvt_d, jvt_q;

  // Write rule
  always_comb begin
    jvt_d = jvt_q;
    if (we_i) begin
      jvt_d.base = wdata_i[XLEN-1:JVT_MODE_W];  // Low 6 bits dropped by alignment
      jvt_d.mode = JVT_MODE_JUMP;               // WARL field stays in jump mode
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      jvt_q <= '0;  // Reads 0 out of reset
    end else begin
      jvt_q <= jvt_d;
    end
  end

  assign rdata_o = jvt_q;
  assign jvt_o   = jvt_q;

endmodule

// ==== hw/cmt_req_if.sv ====
/*
 * Pre-decoded instruction channel
 * Carries one fetch item plus its table-jump decode from the
 * pre-decoder to the expander under a valid/ready handshake
 */
interface cmt_req_if
  import zcmt_pkg::*;
();

  logic               valid;     // Item held by producer
  logic               ready;     // Consumer takes it this cycle
  fetch_item_t        item;      // Original fetch item
  logic               is_table;  // cm.jt or cm.jalt
  jt_kind_e           kind;      // Link kind of the jump
  logic [INDEX_W-1:0] index;     // Table index, inst[9:2]

  modport producer (
    output valid, item, is_table, kind, index,
    input  ready
  );

  modport consumer (
    input  valid, item, is_table, kind, index,
    output ready
  );

endinterface

// ==== hw/zcmt_pkg.sv ====
/*
 * Zcmt table-jump package
 * Shared widths, opcode constants, FSM state and kind enums and the
 * structs passed between fetch, the pre-decoder, the expander and the JVT block
 */
package zcmt_pkg;

  // Datapath widths
  localparam int unsigned XLEN       = 32;  // Data and address width
  localparam int unsigned INDEX_W    = 8;   // cm.jt / cm.jalt table index
  localparam int unsigned JALT_MIN   = 32;  // First index decoded as cm.jalt
  localparam int unsigned JAL_OFF_W  = 21;  // Signed jal immediate range
  localparam int unsigned REG_ADDR_W = 5;   // Register specifier width

  // JVT layout, base is 64-byte aligned
  localparam int unsigned JVT_MODE_W = 6;
  localparam int unsigned JVT_BASE_W = XLEN - JVT_MODE_W;
  localparam logic [JVT_MODE_W-1:0] JVT_MODE_JUMP = 6'd0;  // Only legal mode

  // Opcodes and compressed encoding fields
  localparam logic [6:0] OPCODE_JAL = 7'b110_1111;
  localparam logic [2:0] CMT_FUNCT3 = 3'b101;  // inst[15:13]
  localparam logic [1:0] CMT_OP     = 2'b10;   // inst[1:0]

  // Link registers used by the expanded jal
  localparam logic [REG_ADDR_W-1:0] RD_ZERO = 5'd0;  // x0, plain jump
  localparam logic [REG_ADDR_W-1:0] RD_RA   = 5'd1;  // x1, jump and link

  // Kind of table jump
  typedef enum logic {
    JT_PLAIN = 1'b0,  // cm.jt, rd = x0
    JT_LINK  = 1'b1   // cm.jalt, rd = x1
  } jt_kind_e;

  // Expander FSM
  typedef enum logic [1:0] {
    TJ_IDLE = 2'd0,  // Accepting new items
    TJ_REQ  = 2'd1,  // Table read request pending
    TJ_WAIT = 2'd2   // Waiting for the table response
  } tj_state_e;

  // Item coming from fetch
  typedef struct packed {
    logic [XLEN-1:0] instruction;
    logic [XLEN-1:0] pc;
    logic            is_compressed;
    logic            illegal;
  } fetch_item_t;

  // Item leaving the expander
  typedef struct packed {
    logic [XLEN-1:0] instruction;
    logic            is_compressed;
    logic            illegal;
  } expand_out_t;

  // Jump vector table register
  typedef struct packed {
    logic [JVT_BASE_W-1:0] base;
    logic [JVT_MODE_W-1:0] mode;
  } jvt_t;

endpackage
